// File: source/tso_pkg.sv
// Transport stream output unit shared widths, packet constants and types.
package tso_pkg;

  // ------------------------------
  // Stream widths
  // ------------------------------
  localparam int BYTE_W         = 8;   // One stream byte.
  localparam int WORD_W         = 32;  // One packed FIFO word.
  localparam int BYTES_PER_WORD = 4;   // Byte lanes per word.
  localparam int CLK_DIV_W      = 12;  // Width of the output clock half-period setting.

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [1:0]        src_sel_t;

  // ------------------------------
  // Packet constants
  // ------------------------------
  localparam byte_t SYNC_BYTE   = 8'h47;  // MPEG-2 TS sync value.
  localparam int    PACKET_SIZE = 188;    // Bytes per TS packet.

  // ------------------------------
  // Source select codes
  // ------------------------------
  localparam src_sel_t SRC_TSI1 = 2'd0;  // First transport stream input.
  localparam src_sel_t SRC_TSI2 = 2'd1;  // Second transport stream input.
  localparam src_sel_t SRC_FE   = 2'd2;  // Front-end input.
  // Code 3 selects no source.

endpackage

// File: source/ts_byte_packer.sv
// Input side that selects one byte source, qualifies packet starts and packs bytes into words.
module ts_byte_packer import tso_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  src_sel_t src_sel,     // Static source select.
  input  logic     endian_in,   // 0 packs big-endian, 1 packs little-endian.
  input  byte_t    tsi1_data,
  input  logic     tsi1_wr,
  input  logic     tsi1_start,
  input  logic     tsi1_err,
  input  byte_t    tsi2_data,
  input  logic     tsi2_wr,
  input  logic     tsi2_start,
  input  logic     tsi2_err,
  input  byte_t    fe_data,
  input  logic     fe_wr,
  input  logic     fe_start,
  input  logic     fe_err,
  output word_t    word,        // Packed word, stable while word_wr is high.
  output logic     word_wr      // One-cycle write strobe to the FIFO.
);

  byte_t      sel_data;
  logic       sel_wr;
  logic       sel_start;
  logic       sel_err;
  logic       start_ok;
  logic       sync_hit;
  logic       accept;
  logic       synced;           // Set once the first real packet start was seen.
  logic [1:0] pos;              // Byte position inside the current word.
  word_t      shift_q;

  // ------------------------------
  // Source mux
  // ------------------------------
  always_comb begin
    sel_data  = '0;
    sel_wr    = 1'b0;
    sel_start = 1'b0;
    sel_err   = 1'b0;
    case (src_sel)
      SRC_TSI1: begin
        sel_data  = tsi1_data;
        sel_wr    = tsi1_wr;
        sel_start = tsi1_start;
        sel_err   = tsi1_err;
      end
      SRC_TSI2: begin
        sel_data  = tsi2_data;
        sel_wr    = tsi2_wr;
        sel_start = tsi2_start;
        sel_err   = tsi2_err;
      end
      SRC_FE: begin
        sel_data  = fe_data;
        sel_wr    = fe_wr;
        sel_start = fe_start;
        sel_err   = fe_err;
      end
      default: ;                // Unused code, nothing selected.
    endcase
  end

  assign start_ok = sel_wr & sel_start & ~sel_err;          // Start flag only counts without error.
  assign sync_hit = start_ok & (sel_data == SYNC_BYTE);     // Real packet boundary.
  assign accept   = sel_wr & (synced | sync_hit);           // Drop bytes before the first start.

  // ------------------------------
  // Position and write strobe
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      synced  <= 1'b0;
      pos     <= '0;
      word_wr <= 1'b0;
    end else begin
      // Strobe the word on the cycle after its last byte lands.
      word_wr <= accept & ~sync_hit & (pos == 2'(BYTES_PER_WORD - 1));
      if (sync_hit) begin
        synced <= 1'b1;
        pos    <= 2'd1;             // Sync byte fills lane 0, partial word discarded.
      end else if (accept) begin
        pos <= pos + 2'd1;          // Wraps after the last lane.
      end
    end
  end

  // Shift register, first byte ends up in the top lane for big-endian.
  always_ff @(posedge clk) begin
    if (accept) begin
      if (endian_in)
        shift_q <= {sel_data, shift_q[WORD_W-1:BYTE_W]};   // Little-endian.
      else
        shift_q <= {shift_q[WORD_W-BYTE_W-1:0], sel_data}; // Big-endian.
    end
  end

  assign word = shift_q;

endmodule

// File: source/ts_word_fifo.sv
// Synchronous word FIFO between packer and formatter with a sticky overflow flag.
module ts_word_fifo import tso_pkg::*; #(
  parameter int fifo_depth = 16     // Number of words, 2 or more.
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  word_wr,            // Write strobe from the packer.
  input  word_t word,
  input  logic  rd,                 // One-cycle pop from the formatter.
  output word_t rd_data,            // Head word, valid while not empty.
  output logic  empty,
  output logic  overflow            // Sticky, a word was lost.
);

  typedef logic [$clog2(fifo_depth)-1:0]   ptr_t;
  typedef logic [$clog2(fifo_depth+1)-1:0] cnt_t;

  word_t mem [fifo_depth];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  cnt_t  count;                     // Fill level.
  logic  full;
  logic  push;
  logic  pop;

  // Pointer advance with explicit wrap so any depth works.
  function automatic ptr_t ptr_next(input ptr_t p);
    if (p == ptr_t'(fifo_depth - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign full  = (count == cnt_t'(fifo_depth));
  assign empty = (count == '0);
  assign push  = word_wr & ~full;   // Full FIFO drops the whole word.
  assign pop   = rd & ~empty;

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= word;
  end

  assign rd_data = mem[rd_ptr];     // Head is visible without a read cycle.

  // ------------------------------
  // Pointers, level, overflow
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                  // Idle or push and pop together.
      endcase
      if (word_wr && full)
        overflow <= 1'b1;           // Held until reset.
    end
  end

endmodule

// File: source/ts_clock_gen.sv
// Programmable divider that makes the output byte clock and its falling-edge tick.
module ts_clock_gen import tso_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 out_ena,      // Low parks the clock high.
  input  logic [CLK_DIV_W-1:0] half_period,  // Half period in clk cycles.
  output logic                 pclk,
  output logic                 pclk_fall     // High on the cycle after pclk falls.
);

  logic [CLK_DIV_W-1:0] cnt;                 // Cycles left in this half period.
  logic                 pclk_q;              // Sampled copy for edge detection.
  logic                 expire;

  assign expire = (cnt <= CLK_DIV_W'(1));    // A setting of 0 acts like 1.

  // ------------------------------
  // Divider
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= half_period;                   // First half period after reset is full length.
      pclk <= 1'b1;                          // Idle level is high.
    end else if (!out_ena) begin
      cnt  <= half_period;                   // Start a full half period on enable.
      pclk <= 1'b1;
    end else if (expire) begin
      cnt  <= half_period;
      pclk <= ~pclk;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // Fall detect.
  always_ff @(posedge clk) begin
    if (rst)
      pclk_q <= 1'b1;
    else
      pclk_q <= pclk;
  end

  assign pclk_fall = pclk_q & ~pclk;         // Only a falling edge gives a tick.

endmodule

// File: source/ts_output_formatter.sv
// Output side that unpacks FIFO words into bytes and drives data, valid and packet start.
module ts_output_formatter import tso_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  pclk_fall,        // Output update tick.
  input  word_t rd_data,          // FIFO head word.
  input  logic  empty,
  input  logic  endian_out,       // 0 sends the top lane first, 1 the bottom lane.
  output logic  rd,               // Pop, taken with the first byte of a word.
  output byte_t tso_data,
  output logic  tso_valid,
  output logic  tso_start
);

  word_t      cur_word;           // Word being sent.
  logic [1:0] lane;               // Next lane of cur_word.
  logic       have_word;          // cur_word still has unsent lanes.
  word_t      src_word;
  logic [1:0] src_lane;
  logic [1:0] byte_pos;           // Physical byte position, 0 is the bottom.
  byte_t      next_byte;
  logic       next_valid;
  logic       next_start;
  logic       started;            // A start was already delivered.
  logic [7:0] since_start;        // Bytes delivered since the last start.

  // ------------------------------
  // Next byte selection
  // ------------------------------
  always_comb begin
    // A fresh word sends lane 0 straight from the FIFO head.
    src_word   = have_word ? cur_word : rd_data;
    src_lane   = have_word ? lane : 2'd0;
    byte_pos   = endian_out ? src_lane : ~src_lane;
    next_byte  = src_word[BYTE_W*byte_pos +: BYTE_W];
    next_valid = have_word | ~empty;
  end

  assign rd = pclk_fall & ~have_word & ~empty;

  // Sync only counts on the first byte or a full packet after the last start.
  assign next_start = next_valid & (next_byte == SYNC_BYTE) &
                      (~started | (since_start >= 8'(PACKET_SIZE - 1)));

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      have_word   <= 1'b0;
      lane        <= '0;
      tso_valid   <= 1'b0;
      tso_start   <= 1'b0;
      started     <= 1'b0;
      since_start <= '0;
    end else if (pclk_fall) begin
      tso_valid <= next_valid;    // Cleared when nothing is left.
      tso_start <= next_start;
      if (have_word) begin
        lane <= lane + 2'd1;
        if (lane == 2'(BYTES_PER_WORD - 1))
          have_word <= 1'b0;      // Last lane out.
      end else if (!empty) begin
        lane      <= 2'd1;        // Lane 0 goes out on this tick.
        have_word <= 1'b1;
      end
      if (next_valid) begin
        if (next_start) begin
          started     <= 1'b1;
          since_start <= '0;
        end else if (since_start != 8'hff) begin
          since_start <= since_start + 8'd1;  // Saturates on long gaps in framing.
        end
      end
    end
  end

  // Payload registers.
  always_ff @(posedge clk) begin
    if (pclk_fall) begin
      if (next_valid)
        tso_data <= next_byte;    // Holds the last byte while idle.
      if (rd)
        cur_word <= rd_data;
    end
  end

endmodule

// File: source/tso_top.sv
// Transport stream output unit top level joining packer, FIFO, clock divider and formatter.
module tso_top import tso_pkg::*; #(
  parameter int fifo_depth = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  src_sel_t             src_sel,
  input  logic                 endian_in,
  input  logic                 endian_out,
  input  logic [CLK_DIV_W-1:0] half_period,
  input  logic                 out_ena,
  input  byte_t                tsi1_data,
  input  logic                 tsi1_wr,
  input  logic                 tsi1_start,
  input  logic                 tsi1_err,
  input  byte_t                tsi2_data,
  input  logic                 tsi2_wr,
  input  logic                 tsi2_start,
  input  logic                 tsi2_err,
  input  byte_t                fe_data,
  input  logic                 fe_wr,
  input  logic                 fe_start,
  input  logic                 fe_err,
  output byte_t                tso_data,
  output logic                 tso_valid,
  output logic                 tso_start,
  output logic                 tso_pclk,
  output logic                 overflow
);

  word_t word;        // Packer to FIFO.
  logic  word_wr;
  word_t rd_data;     // FIFO to formatter.
  logic  empty;
  logic  rd;
  logic  pclk_fall;   // Divider tick.

  // ------------------------------
  // Input side and buffer
  // ------------------------------
  ts_byte_packer u_packer (
    .clk, .rst, .src_sel, .endian_in,
    .tsi1_data, .tsi1_wr, .tsi1_start, .tsi1_err,
    .tsi2_data, .tsi2_wr, .tsi2_start, .tsi2_err,
    .fe_data, .fe_wr, .fe_start, .fe_err,
    .word, .word_wr
  );

  ts_word_fifo #(.fifo_depth(fifo_depth)) u_fifo (
    .clk, .rst, .word_wr, .word, .rd,
    .rd_data, .empty, .overflow
  );

  // ------------------------------
  // Output side
  // ------------------------------
  ts_clock_gen u_clock_gen (
    .clk, .rst, .out_ena, .half_period,
    .pclk(tso_pclk), .pclk_fall
  );

  ts_output_formatter u_formatter (
    .clk, .rst, .pclk_fall, .rd_data, .empty, .endian_out,
    .rd, .tso_data, .tso_valid, .tso_start
  );

endmodule

// File: sim/tb_tso.sv
// Testbench for the transport stream output unit with random packets and a byte-level model.
module tb_tso import tso_pkg::*; ();

  localparam int pkts_per_phase = 2;
  localparam int n_packets      = 4 * pkts_per_phase;                // Four checked phases.
  localparam int cycle_limit    = n_packets * PACKET_SIZE * 10 + 1000;

  logic                 clk = 1'b0;
  logic                 rst;
  src_sel_t             src_sel;
  logic                 endian_in;
  logic                 endian_out;
  logic [CLK_DIV_W-1:0] half_period;
  logic                 out_ena;
  byte_t                tsi1_data;
  logic                 tsi1_wr;
  logic                 tsi1_start;
  logic                 tsi1_err;
  byte_t                tsi2_data;
  logic                 tsi2_wr;
  logic                 tsi2_start;
  logic                 tsi2_err;
  byte_t                fe_data;
  logic                 fe_wr;
  logic                 fe_start;
  logic                 fe_err;
  byte_t                tso_data;
  logic                 tso_valid;
  logic                 tso_start;
  logic                 tso_pclk;
  logic                 overflow;

  byte_t exp_data_q [$];                 // Expected output bytes in order.
  logic  exp_start_q [$];                // Packet-start flag per expected byte.
  byte_t grp_data [BYTES_PER_WORD];      // Bytes of the word being assembled.
  logic  grp_first [BYTES_PER_WORD];
  int    grp_n;
  int    cycles = 0;
  logic  prev_pclk = 1'b1;
  logic  fell;
  byte_t exp_d;
  logic  exp_s;

  tso_top #(.fifo_depth(16)) uut (
    .clk, .rst, .src_sel, .endian_in, .endian_out, .half_period, .out_ena,
    .tsi1_data, .tsi1_wr, .tsi1_start, .tsi1_err,
    .tsi2_data, .tsi2_wr, .tsi2_start, .tsi2_err,
    .fe_data, .fe_wr, .fe_start, .fe_err,
    .tso_data, .tso_valid, .tso_start, .tso_pclk, .overflow
  );

  always #10 clk = ~clk;                 // Period of 20.

  // ------------------------------
  // Checks and timeout
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("test failed");
      $fatal(1, "Value mismatch on %s.", name);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the output never drained", cycles);
      $display("test failed");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  // Each output byte is held one pclk period, so it is sampled once per pclk fall.
  always @(negedge clk) begin
    fell      = prev_pclk & ~tso_pclk;
    prev_pclk = tso_pclk;
    if (fell && tso_valid && exp_data_q.size() == 0) begin
      $display("An output byte 0x%0h arrived while no byte was expected", tso_data);
      $display("test failed");
      $fatal(1, "Unexpected output byte.");
    end else if (fell && tso_valid) begin
      exp_d = exp_data_q.pop_front();
      exp_s = exp_start_q.pop_front();
      check_value("tso_data", 32'(tso_data), 32'(exp_d));
      check_value("tso_start", 32'(tso_start), 32'(exp_s));
    end else if (fell) begin
      check_value("tso_start", 32'(tso_start), 32'h0);   // No start without valid.
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  // Groups accepted bytes in fours, reversed when the two byte orders differ.
  task automatic model_push(input byte_t data, input logic first);
    grp_data[grp_n]  = data;
    grp_first[grp_n] = first;
    grp_n++;
    if (grp_n == BYTES_PER_WORD) begin
      for (int k = 0; k < BYTES_PER_WORD; k++) begin
        if (endian_in != endian_out) begin
          exp_data_q.push_back(grp_data[BYTES_PER_WORD-1-k]);
          exp_start_q.push_back(grp_first[BYTES_PER_WORD-1-k]);
        end else begin
          exp_data_q.push_back(grp_data[k]);
          exp_start_q.push_back(grp_first[k]);
        end
      end
      grp_n = 0;
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic apply_reset(input src_sel_t sel, input logic ein, input logic eout,
                             input logic ena);
    @(posedge clk);
    rst        <= 1'b1;
    src_sel    <= sel;
    endian_in  <= ein;
    endian_out <= eout;
    out_ena    <= ena;
    tsi1_wr    <= 1'b0;                  // Quiet sources across the release edge.
    tsi2_wr    <= 1'b0;
    fe_wr      <= 1'b0;
    repeat (3) @(posedge clk);
    rst   <= 1'b0;
    grp_n = 0;
  endtask

  // One clock of traffic. Unselected sources get random bytes and flags.
  task automatic drive_cycle(input logic wr, input byte_t data, input logic start,
                             input logic err);
    logic [31:0] r;
    @(posedge clk);
    r = $urandom;
    tsi1_data  <= r[7:0];
    tsi1_wr    <= r[24];
    tsi1_start <= r[25];
    tsi1_err   <= r[26];
    tsi2_data  <= r[15:8];
    tsi2_wr    <= r[27];
    tsi2_start <= r[28];
    tsi2_err   <= r[29];
    fe_data    <= r[23:16];
    fe_wr      <= r[30];
    fe_start   <= r[31];
    fe_err     <= r[26];
    case (src_sel)
      SRC_TSI1: begin
        tsi1_data  <= data;
        tsi1_wr    <= wr;
        tsi1_start <= start;
        tsi1_err   <= err;
      end
      SRC_TSI2: begin
        tsi2_data  <= data;
        tsi2_wr    <= wr;
        tsi2_start <= start;
        tsi2_err   <= err;
      end
      SRC_FE: begin
        fe_data  <= data;
        fe_wr    <= wr;
        fe_start <= start;
        fe_err   <= err;
      end
      default: ;
    endcase
  endtask

  task automatic send_byte(input byte_t data, input logic start, input logic err,
                           input int gap);
    drive_cycle(1'b1, data, start, err);
    repeat (gap) drive_cycle(1'b0, 8'h00, 1'b0, 1'b0);
  endtask

  function automatic byte_t random_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  // Junk and an errored sync start that are all dropped before the first real packet.
  task automatic send_preamble();
    send_byte(random_byte(), 1'b0, 1'b0, 6);
    send_byte(SYNC_BYTE, 1'b1, 1'b1, 6);
    repeat (3) send_byte(random_byte(), 1'b0, 1'b0, 6);
  endtask

  task automatic send_packet();
    logic [31:0] r;
    byte_t       d;
    logic        st;
    logic        er;
    int          gap;
    for (int i = 0; i < PACKET_SIZE; i++) begin
      r  = $urandom;
      st = 1'b0;
      er = 1'b0;
      if (i == 0) begin
        d  = SYNC_BYTE;
        st = 1'b1;
      end else if (i < BYTES_PER_WORD) begin
        d = (r[7:0] == SYNC_BYTE) ? 8'h00 : r[7:0];   // Keeps the first word unambiguous.
      end else if (r[11:8] == 4'h0) begin
        d  = SYNC_BYTE;                               // Sync value inside the payload.
        st = r[12];
        er = r[12];
      end else begin
        d = r[7:0];
      end
      gap = 6 + int'(r[31:16] % 3);
      model_push(d, (i == 0));
      send_byte(d, st, er, gap);
    end
  endtask

  task automatic run_phase(input src_sel_t sel, input logic ein, input logic eout);
    $display("Phase: source %0d, endian in %0d, endian out %0d", sel, ein, eout);
    apply_reset(sel, ein, eout, 1'b1);
    send_preamble();
    repeat (pkts_per_phase) send_packet();
    while (exp_data_q.size() != 0)
      drive_cycle(1'b0, 8'h00, 1'b0, 1'b0);
    repeat (12) drive_cycle(1'b0, 8'h00, 1'b0, 1'b0);
    @(negedge clk);
    check_value("overflow", 32'(overflow), 32'h0);
  endtask

  // Parked output clock lets the FIFO fill until the 17th word is lost.
  task automatic overflow_phase();
    $display("Phase: FIFO overflow");
    apply_reset(SRC_TSI1, 1'b0, 1'b0, 1'b0);
    send_byte(SYNC_BYTE, 1'b1, 1'b0, 0);
    for (int i = 1; i < 16 * BYTES_PER_WORD; i++)
      send_byte(random_byte(), 1'b0, 1'b0, 0);
    repeat (3) drive_cycle(1'b0, 8'h00, 1'b0, 1'b0);
    @(negedge clk);
    check_value("overflow", 32'(overflow), 32'h0);
    repeat (BYTES_PER_WORD) send_byte(random_byte(), 1'b0, 1'b0, 0);
    repeat (3) drive_cycle(1'b0, 8'h00, 1'b0, 1'b0);
    @(negedge clk);
    check_value("overflow", 32'(overflow), 32'h1);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h9788));
    grp_n = 0;
    rst         <= 1'b1;
    src_sel     <= SRC_TSI1;
    endian_in   <= 1'b0;
    endian_out  <= 1'b0;
    half_period <= 12'd2;                // One output byte every 4 clocks.
    out_ena     <= 1'b1;                 // Divider enabled through reset.
    tsi1_data   <= '0;
    tsi1_wr     <= 1'b0;
    tsi1_start  <= 1'b0;
    tsi1_err    <= 1'b0;
    tsi2_data   <= '0;
    tsi2_wr     <= 1'b0;
    tsi2_start  <= 1'b0;
    tsi2_err    <= 1'b0;
    fe_data     <= '0;
    fe_wr       <= 1'b0;
    fe_start    <= 1'b0;
    fe_err      <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("tso_valid", 32'(tso_valid), 32'h0);   // Reset state.
    check_value("tso_start", 32'(tso_start), 32'h0);
    check_value("overflow", 32'(overflow), 32'h0);
    check_value("tso_pclk", 32'(tso_pclk), 32'h1);
    run_phase(SRC_TSI1, 1'b0, 1'b0);
    run_phase(SRC_TSI1, 1'b0, 1'b1);
    run_phase(SRC_TSI2, 1'b1, 1'b1);
    run_phase(SRC_FE, 1'b1, 1'b0);
    overflow_phase();
    $display("test passed");
    $finish;
  end

endmodule

// File: all.f
source/tso_pkg.sv
source/ts_byte_packer.sv
source/ts_word_fifo.sv
source/ts_clock_gen.sv
source/ts_output_formatter.sv
source/tso_top.sv
sim/tb_tso.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log.
verilator --binary --timing --top-module tb_tso -f all.f -o tb_tso > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_tso > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && echo "Simulation OK" \
  || { echo "Simulation FAILED"; exit 1; }
